// File: src/vrf_pkg.sv
// shared widths and types for the 512x32 vector register file
// four banks interleaved on word address bits [1:0], row in bits [8:2]
// only the three write masks below are legal, all others write nothing

`default_nettype none

package vrf_pkg;

   localparam int WORD_W     = 32;
   localparam int ADDR_W     = 9;
   localparam int NUM_BANKS  = 4;
   localparam int BANK_SEL_W = 2;
   localparam int ROW_W      = ADDR_W - BANK_SEL_W;
   localparam int BANK_ROWS  = 1 << ROW_W;

   // rd0 and wr0 move one word per bank, rd1 moves two words
   localparam int WIDE_W = NUM_BANKS * WORD_W;
   localparam int DUAL_W = 2 * WORD_W;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [ADDR_W-1:0]     vrf_addr_t;
   typedef logic [ROW_W-1:0]      row_t;
   typedef logic [BANK_SEL_W-1:0] bank_sel_t;
   typedef logic [WIDE_W-1:0]     wide_t;
   typedef logic [DUAL_W-1:0]     dual_t;
   typedef logic [NUM_BANKS-1:0]  wr_mask_t;

   // one word anywhere, two words at an even address, four at a multiple of four
   localparam wr_mask_t WR_MASK_WORD = 4'b0001;
   localparam wr_mask_t WR_MASK_DUAL = 4'b0011;
   localparam wr_mask_t WR_MASK_QUAD = 4'b1111;

endpackage

`default_nettype wire

// File: src/vrf_access_if.sv
// per-bank read rows and write controls, from access decode to the banks
// no handshake, every field is valid in every cycle

`default_nettype none

interface vrf_access_if;

   // one entry per bank, index is the bank number
   vrf_pkg::row_t [vrf_pkg::NUM_BANKS-1:0] rd0_row;
   vrf_pkg::row_t [vrf_pkg::NUM_BANKS-1:0] rd1_row;
   logic [vrf_pkg::NUM_BANKS-1:0]           wr_en;
   vrf_pkg::word_t [vrf_pkg::NUM_BANKS-1:0] wr_data;

   // all banks share the row of a write
   vrf_pkg::row_t wr_row;

   modport decode (
      output rd0_row,
      output rd1_row,
      output wr_en,
      output wr_data,
      output wr_row
   );

   modport bank (
      input rd0_row,
      input rd1_row,
      input wr_en,
      input wr_data,
      input wr_row
   );

endinterface

`default_nettype wire

// File: src/vrf_read_if.sv
// bank read lanes and the lane offsets registered with them
// lanes are in bank order, alignment puts them back in address order

`default_nettype none

interface vrf_read_if;

   vrf_pkg::word_t [vrf_pkg::NUM_BANKS-1:0] rd0_lanes;
   vrf_pkg::word_t [vrf_pkg::NUM_BANKS-1:0] rd1_lanes;
   vrf_pkg::bank_sel_t                      rd0_offset;
   vrf_pkg::bank_sel_t                      rd1_offset;

   modport bank (
      output rd0_lanes,
      output rd1_lanes,
      output rd0_offset,
      output rd1_offset
   );

   modport align (
      input rd0_lanes,
      input rd1_lanes,
      input rd0_offset,
      input rd1_offset
   );

endinterface

`default_nettype wire

// File: src/vrf_access_decode.sv
// spreads read addresses and wr0 onto the four banks, purely combinational
// addresses wrap modulo 512, so a read at 511 continues at word 0
// an illegal mask or a misaligned dual/quad write enables no bank
// disabled banks get zero data, unused rd1 banks get row zero

`default_nettype none

module vrf_access_decode (
   input  vrf_pkg::vrf_addr_t rd0_addr,
   input  vrf_pkg::vrf_addr_t rd1_addr,
   input  vrf_pkg::vrf_addr_t wr0_addr,
   input  vrf_pkg::wr_mask_t  wr0_en,
   input  vrf_pkg::wide_t     wr0_data,
   vrf_access_if.decode       acc
);

   vrf_pkg::vrf_addr_t rd1_next;
   vrf_pkg::bank_sel_t rd1_low;
   vrf_pkg::bank_sel_t rd1_low_next;
   vrf_pkg::bank_sel_t wr_low;
   logic               wr_word;
   logic               wr_dual;
   logic               wr_quad;

   assign rd1_next     = rd1_addr + vrf_pkg::vrf_addr_t'(1);
   assign rd1_low      = rd1_addr[vrf_pkg::BANK_SEL_W-1:0];
   assign rd1_low_next = rd1_low + vrf_pkg::bank_sel_t'(1);

   assign wr_low = wr0_addr[vrf_pkg::BANK_SEL_W-1:0];

   // legal mask and alignment combinations
   assign wr_word = (wr0_en == vrf_pkg::WR_MASK_WORD);
   assign wr_dual = (wr0_en == vrf_pkg::WR_MASK_DUAL) && !wr0_addr[0];
   assign wr_quad = (wr0_en == vrf_pkg::WR_MASK_QUAD) && (wr_low == '0);

   assign acc.wr_row = wr0_addr[vrf_pkg::ADDR_W-1:vrf_pkg::BANK_SEL_W];

   for (genvar b = 0; b < vrf_pkg::NUM_BANKS; b++)
   begin : g_bank
      vrf_pkg::bank_sel_t rd0_step;
      vrf_pkg::vrf_addr_t rd0_bank_addr;
      vrf_pkg::bank_sel_t wr_step;
      logic               wr_hit;

      // which of the four consecutive words lands in this bank
      assign rd0_step      = vrf_pkg::bank_sel_t'(b) - rd0_addr[vrf_pkg::BANK_SEL_W-1:0];
      assign rd0_bank_addr = rd0_addr + vrf_pkg::vrf_addr_t'(rd0_step);
      assign acc.rd0_row[b] = rd0_bank_addr[vrf_pkg::ADDR_W-1:vrf_pkg::BANK_SEL_W];

      always_comb
      begin
         if (rd1_low == vrf_pkg::bank_sel_t'(b))
         begin
            acc.rd1_row[b] = rd1_addr[vrf_pkg::ADDR_W-1:vrf_pkg::BANK_SEL_W];
         end
         else if (rd1_low_next == vrf_pkg::bank_sel_t'(b))
         begin
            acc.rd1_row[b] = rd1_next[vrf_pkg::ADDR_W-1:vrf_pkg::BANK_SEL_W];
         end
         else
         begin
            acc.rd1_row[b] = '0;
         end
      end

      // word index inside wr0_data that belongs to this bank
      assign wr_step = vrf_pkg::bank_sel_t'(b) - wr_low;
      assign wr_hit  = wr_quad ||
                       (wr_dual && (wr_step <= vrf_pkg::bank_sel_t'(1))) ||
                       (wr_word && (wr_step == '0));

      assign acc.wr_en[b]   = wr_hit;
      assign acc.wr_data[b] = wr_hit ?
                              wr0_data[wr_step * vrf_pkg::WORD_W +: vrf_pkg::WORD_W] : '0;
   end

endmodule

`default_nettype wire

// File: src/vrf_bank.sv
// one 128x32 bank, one write port and two registered read ports
// a read of the row being written returns the old word
// contents are not reset

`default_nettype none

module vrf_bank (
   input  logic               clk,
   input  logic               wr_en,
   input  vrf_pkg::row_t      wr_row,
   input  vrf_pkg::word_t     wr_data,
   input  vrf_pkg::row_t      rd_a_row,
   input  vrf_pkg::row_t      rd_b_row,
   output vrf_pkg::word_t     rd_a_data,
   output vrf_pkg::word_t     rd_b_data
);

   vrf_pkg::word_t mem [vrf_pkg::BANK_ROWS];

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_row] <= wr_data;
      end
   end

   // both reads sample the array before the write of the same edge lands
   always_ff @(posedge clk)
   begin
      rd_a_data <= mem[rd_a_row];
      rd_b_data <= mem[rd_b_row];
   end

endmodule

`default_nettype wire

// File: src/vrf_bank_array.sv
// four interleaved banks, port a serves rd0 and port b serves rd1
// lane offsets are registered alongside the read so alignment
// rotates with the address that produced the data
// only the offset registers see rst

`default_nettype none

module vrf_bank_array (
   input  logic               clk,
   input  logic               rst,
   input  vrf_pkg::bank_sel_t rd0_addr_low,
   input  vrf_pkg::bank_sel_t rd1_addr_low,
   vrf_access_if.bank         acc,
   vrf_read_if.bank           rd
);

   for (genvar b = 0; b < vrf_pkg::NUM_BANKS; b++)
   begin : g_bank
      vrf_bank vrf_bank_i (
         .clk       (clk),
         .wr_en     (acc.wr_en[b]),
         .wr_row    (acc.wr_row),
         .wr_data   (acc.wr_data[b]),
         .rd_a_row  (acc.rd0_row[b]),
         .rd_b_row  (acc.rd1_row[b]),
         .rd_a_data (rd.rd0_lanes[b]),
         .rd_b_data (rd.rd1_lanes[b])
      );
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rd.rd0_offset <= '0;
         rd.rd1_offset <= '0;
      end
      else
      begin
         rd.rd0_offset <= rd0_addr_low;
         rd.rd1_offset <= rd1_addr_low;
      end
   end

endmodule

`default_nettype wire

// File: src/vrf_read_align.sv
// rotates bank lanes back into address order, combinational
// word i of a read comes from bank (offset + i) mod 4
// rd1 uses only the two banks starting at its offset

`default_nettype none

module vrf_read_align (
   vrf_read_if.align        rd,
   output vrf_pkg::wide_t   rd0_data,
   output vrf_pkg::dual_t   rd1_data
);

   for (genvar i = 0; i < vrf_pkg::NUM_BANKS; i++)
   begin : g_rd0
      vrf_pkg::bank_sel_t src;

      assign src = rd.rd0_offset + vrf_pkg::bank_sel_t'(i);
      assign rd0_data[i * vrf_pkg::WORD_W +: vrf_pkg::WORD_W] = rd.rd0_lanes[src];
   end

   for (genvar i = 0; i < vrf_pkg::DUAL_W / vrf_pkg::WORD_W; i++)
   begin : g_rd1
      vrf_pkg::bank_sel_t src;

      // wraps from bank 3 back to bank 0
      assign src = rd.rd1_offset + vrf_pkg::bank_sel_t'(i);
      assign rd1_data[i * vrf_pkg::WORD_W +: vrf_pkg::WORD_W] = rd.rd1_lanes[src];
   end

endmodule

`default_nettype wire

// File: src/vrf_top.sv
// 512x32 vector register file, rd0 four words, rd1 two words, wr0 1/2/4 words
// reads of any word address return data one cycle later, wrapping at 511
// wr0 needs an even address for two words and a multiple of four for four
// a read and a write of the same word in one cycle return the old value

`default_nettype none

module vrf_top (
   input  logic               clk,
   input  logic               rst,
   input  vrf_pkg::vrf_addr_t rd0_addr,
   input  vrf_pkg::vrf_addr_t rd1_addr,
   input  vrf_pkg::vrf_addr_t wr0_addr,
   input  vrf_pkg::wr_mask_t  wr0_en,
   input  vrf_pkg::wide_t     wr0_data,
   output vrf_pkg::wide_t     rd0_data,
   output vrf_pkg::dual_t     rd1_data
);

   vrf_access_if acc ();
   vrf_read_if   rd ();

   vrf_access_decode vrf_access_decode_i (
      .rd0_addr (rd0_addr),
      .rd1_addr (rd1_addr),
      .wr0_addr (wr0_addr),
      .wr0_en   (wr0_en),
      .wr0_data (wr0_data),
      .acc      (acc.decode)
   );

   // low address bits pick the rotation applied to the returned lanes
   vrf_bank_array vrf_bank_array_i (
      .clk          (clk),
      .rst          (rst),
      .rd0_addr_low (rd0_addr[vrf_pkg::BANK_SEL_W-1:0]),
      .rd1_addr_low (rd1_addr[vrf_pkg::BANK_SEL_W-1:0]),
      .acc          (acc.bank),
      .rd           (rd.bank)
   );

   vrf_read_align vrf_read_align_i (
      .rd       (rd.align),
      .rd0_data (rd0_data),
      .rd1_data (rd1_data)
   );

endmodule

`default_nettype wire

// File: tests/tb_vrf_tasks.svh
// directed tests and cycle helpers, included inside tb_vrf
// the model follows the legal write rules, any other mask leaves it unchanged
// expected read data is taken before the write of the same cycle

`ifndef TB_VRF_TASKS_SVH
`define TB_VRF_TASKS_SVH

function automatic vrf_pkg::word_t fill_word(input vrf_pkg::vrf_addr_t a);
   // odd multiplier, so every address gives its own word
   return ({23'h0, a} * 32'h9e37_79b1) ^ 32'h5a5a_0000;
endfunction

function automatic void model_write(input vrf_pkg::vrf_addr_t a, input vrf_pkg::wr_mask_t m,
                                    input vrf_pkg::wide_t d);
   int n;
   n = 0;
   if (m == vrf_pkg::WR_MASK_WORD)
   begin
      n = 1;
   end
   else if (m == vrf_pkg::WR_MASK_DUAL && a[0] == 1'b0)
   begin
      n = 2;
   end
   else if (m == vrf_pkg::WR_MASK_QUAD && a[1:0] == 2'b00)
   begin
      n = 4;
   end
   for (int i = 0; i < n; i++)
   begin
      model[a + vrf_pkg::vrf_addr_t'(i)] = d[i * vrf_pkg::WORD_W +: vrf_pkg::WORD_W];
   end
endfunction

// word i of a read is model word (addr + i) mod 512
function automatic vrf_pkg::wide_t wide_expect(input vrf_pkg::vrf_addr_t a);
   vrf_pkg::wide_t w;
   for (int i = 0; i < 4; i++)
   begin
      w[i * vrf_pkg::WORD_W +: vrf_pkg::WORD_W] = model[a + vrf_pkg::vrf_addr_t'(i)];
   end
   return w;
endfunction

task automatic compare(input string name, input vrf_pkg::wide_t expected,
                       input vrf_pkg::wide_t actual);
   if (actual !== expected)
   begin
      $display("ERROR %s expected %h got %h", name, expected, actual);
      fail_count++;
      test_errors++;
   end
   else
   begin
      pass_count++;
   end
endtask

task automatic end_test(input string name);
   if (test_errors == 0)
   begin
      $display("%s: passed", name);
   end
   else
   begin
      $display("%s: failed with %0d errors", name, test_errors);
   end
   test_errors = 0;
endtask

// drive one set of inputs, the DUT samples them at the next rising edge
task automatic run_cycle(input vrf_pkg::vrf_addr_t r0, input vrf_pkg::vrf_addr_t r1,
                         input vrf_pkg::vrf_addr_t wa, input vrf_pkg::wr_mask_t wm,
                         input vrf_pkg::wide_t wd, input bit check_rd);
   vrf_pkg::wide_t exp0;
   vrf_pkg::wide_t exp1;
   vrf_pkg::wide_t rd1_words;
   exp0 = wide_expect(r0);
   rd1_words = wide_expect(r1);
   exp1 = {64'h0, rd1_words[63:0]};
   model_write(wa, wm, wd);
   @(posedge clk);
   rd0_addr <= r0;
   rd1_addr <= r1;
   wr0_addr <= wa;
   wr0_en   <= wm;
   wr0_data <= wd;
   @(posedge clk);
   wr0_en <= '0;
   @(negedge clk);
   if (check_rd)
   begin
      compare("rd0_data", exp0, rd0_data);
      compare("rd1_data", exp1, {64'h0, rd1_data});
   end
endtask

task automatic write_op(input vrf_pkg::vrf_addr_t wa, input vrf_pkg::wr_mask_t wm,
                        input vrf_pkg::wide_t wd);
   run_cycle(rd0_addr, rd1_addr, wa, wm, wd, 1'b0);
endtask

task automatic read_op(input vrf_pkg::vrf_addr_t r0, input vrf_pkg::vrf_addr_t r1);
   run_cycle(r0, r1, '0, '0, '0, 1'b1);
endtask

task automatic quad_write_readback();
   vrf_pkg::vrf_addr_t a;
   for (int row = 0; row < 128; row++)
   begin
      a = vrf_pkg::vrf_addr_t'(row * 4);
      write_op(a, vrf_pkg::WR_MASK_QUAD, {fill_word(a + 9'd3), fill_word(a + 9'd2),
                                          fill_word(a + 9'd1), fill_word(a)});
   end
   for (int row = 0; row < 128; row++)
   begin
      read_op(vrf_pkg::vrf_addr_t'(row * 4), vrf_pkg::vrf_addr_t'(row * 4));
   end
   end_test("quad_write_readback");
endtask

task automatic single_word_writes();
   vrf_pkg::vrf_addr_t addrs [8] = '{9'd20, 9'd21, 9'd22, 9'd23,
                                     9'd508, 9'd509, 9'd510, 9'd511};
   for (int i = 0; i < 8; i++)
   begin
      write_op(addrs[i], vrf_pkg::WR_MASK_WORD, {96'h0, 32'hc0de_0000 ^ {23'h0, addrs[i]}});
   end
   for (int i = 0; i < 8; i++)
   begin
      read_op(addrs[i], addrs[i]);
   end
   end_test("single_word_writes");
endtask

task automatic dual_word_writes();
   vrf_pkg::vrf_addr_t addrs [4] = '{9'd40, 9'd42, 9'd130, 9'd510};
   for (int i = 0; i < 4; i++)
   begin
      write_op(addrs[i], vrf_pkg::WR_MASK_DUAL,
               {64'h0, 32'hd0a1_1111 ^ {23'h0, addrs[i]}, 32'hd0a1_0000 ^ {23'h0, addrs[i]}});
   end
   // rd0 spans the word below, rd1 the two words above
   for (int i = 0; i < 4; i++)
   begin
      read_op(addrs[i] - 9'd1, addrs[i] + 9'd2);
   end
   end_test("dual_word_writes");
endtask

task automatic unaligned_reads();
   vrf_pkg::vrf_addr_t addrs [9] = '{9'd1, 9'd2, 9'd3, 9'd101, 9'd202, 9'd303,
                                     9'd509, 9'd510, 9'd511};
   for (int i = 0; i < 9; i++)
   begin
      read_op(addrs[i], addrs[8 - i]);
   end
   end_test("unaligned_reads");
endtask

task automatic illegal_masks_ignored();
   vrf_pkg::vrf_addr_t addrs [8] = '{9'd61, 9'd66, 9'd64, 9'd65, 9'd66, 9'd67, 9'd64, 9'd62};
   vrf_pkg::wr_mask_t  masks [8] = '{4'b0011, 4'b1111, 4'b0010, 4'b0101,
                                     4'b1000, 4'b0111, 4'b1110, 4'b1100};
   for (int i = 0; i < 8; i++)
   begin
      write_op(addrs[i], masks[i], {4{32'hdead_beef}});
      read_op({addrs[i][8:2], 2'b00}, addrs[i]);
   end
   end_test("illegal_masks_ignored");
endtask

task automatic random_traffic();
   logic [31:0]        r;
   vrf_pkg::vrf_addr_t wa;
   vrf_pkg::vrf_addr_t r0;
   vrf_pkg::vrf_addr_t r1;
   vrf_pkg::wr_mask_t  wm;
   vrf_pkg::wide_t     wd;
   for (int n = 0; n < RANDOM_OPS; n++)
   begin
      r  = $random(seed);
      wm = (r[10:9] == 2'd0) ? vrf_pkg::WR_MASK_WORD :
           (r[10:9] == 2'd1) ? vrf_pkg::WR_MASK_DUAL : vrf_pkg::WR_MASK_QUAD;
      // dual needs bit 0 clear, quad needs bits 1 and 0 clear
      wa = r[8:0] & ~{7'h0, wm[3], wm[1]};
      wd = {$random(seed), $random(seed), $random(seed), $random(seed)};
      r  = $random(seed);
      r0 = r[8:0];
      r1 = r[17:9];
      // every fourth cycle reads the word being written
      if (n % 4 == 0)
      begin
         r0 = wa;
         r1 = wa;
      end
      run_cycle(r0, r1, wa, wm, wd, 1'b1);
   end
   end_test("random_traffic");
endtask

`endif

// File: tests/tb_vrf.sv
// testbench for vrf_top, directed tests against a 512-word reference model
// the memory has no reset, so the first test fills every word before other reads
// each operation takes two clock cycles and read data is checked at the falling edge

`default_nettype none

module tb_vrf;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD    = 100;
   localparam int RESET_CYCLES  = 4;
   localparam int RANDOM_OPS    = 200;
   // operations of each test, in the order the tests run
   localparam int NUM_OPS       = 256 + 16 + 8 + 9 + 16 + RANDOM_OPS;
   localparam int CYCLES_PER_OP = 2;
   localparam int MARGIN_CYCLES = 50;

   logic               clk;
   logic               rst;
   vrf_pkg::vrf_addr_t rd0_addr;
   vrf_pkg::vrf_addr_t rd1_addr;
   vrf_pkg::vrf_addr_t wr0_addr;
   vrf_pkg::wr_mask_t  wr0_en;
   vrf_pkg::wide_t     wr0_data;
   vrf_pkg::wide_t     rd0_data;
   vrf_pkg::dual_t     rd1_data;

   vrf_pkg::word_t     model [512];
   integer             seed;
   int                 pass_count;
   int                 fail_count;
   int                 test_errors;

   vrf_top vrf_top_i (
      .clk      (clk),
      .rst      (rst),
      .rd0_addr (rd0_addr),
      .rd1_addr (rd1_addr),
      .wr0_addr (wr0_addr),
      .wr0_en   (wr0_en),
      .wr0_data (wr0_data),
      .rd0_data (rd0_data),
      .rd1_data (rd1_data)
   );

   `include "tb_vrf_tasks.svh"

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // watchdog sized from the number of operations plus reset and margin
   initial
   begin
      #((NUM_OPS * CYCLES_PER_OP + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("timeout: the tests did not complete in the expected number of cycles");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      seed        = 32'h5fbb;
      pass_count  = 0;
      fail_count  = 0;
      test_errors = 0;
      rst         = 1'b1;
      rd0_addr    = '0;
      rd1_addr    = '0;
      wr0_addr    = '0;
      wr0_en      = '0;
      wr0_data    = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      quad_write_readback();
      single_word_writes();
      dual_word_writes();
      unaligned_reads();
      illegal_masks_ignored();
      random_traffic();

      $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+tests
src/vrf_pkg.sv
src/vrf_access_if.sv
src/vrf_read_if.sv
src/vrf_access_decode.sv
src/vrf_bank.sv
src/vrf_bank_array.sv
src/vrf_read_align.sv
src/vrf_top.sv
tests/tb_vrf.sv

// File: Makefile
# Verilator build and run of the vector register file testbench

VERILATOR ?= verilator
TOP       ?= tb_vrf
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR FLAGS PASS_MSG"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
